/* Bender.yml */
package:
  name: video_core

sources:
  - common/video_pkg.sv
  - verilog/video_core_ctrl.sv
  - verilog/video_fetch.sv
  - verilog/pixel_afifo.sv
  - verilog/video_timing.sv
  - verilog/video_core.sv
  - target: simulation
    files:
      - sim/fb_memory.sv
      - sim/tb_video_core.sv

/* common/video_pkg.sv */
`default_nettype none

package video_pkg;

// wishbone bus widths
localparam int WB_ADDR_W = 32;
localparam int WB_DATA_W = 32;
localparam int WB_SEL_W  = WB_DATA_W / 8;

// pixel and counter widths
localparam int PIXEL_W = 24;
localparam int COORD_W = 10;

// byte address on the bus
typedef logic [WB_ADDR_W-1:0] wb_addr_t;
typedef logic [WB_DATA_W-1:0] wb_data_t;
typedef logic [WB_SEL_W-1:0]  wb_sel_t;

// blue in the high byte then green then red
typedef logic [PIXEL_W-1:0] pixel_t;

// one horizontal or vertical position
typedef logic [COORD_W-1:0] coord_t;

// register byte offsets on the config port
localparam logic [3:0] REG_CTRL   = 4'h0;
localparam logic [3:0] REG_BASE   = 4'h4;
localparam logic [3:0] REG_STATUS = 4'h8;

// bit positions inside the registers
localparam int CTRL_ENABLE_BIT      = 0;
localparam int STATUS_UNDERFLOW_BIT = 0;

endpackage

`default_nettype wire

/* sim/fb_memory.sv */
`timescale 1ns/10ps
`default_nettype none

module fb_memory (
	input  wire                      clk_i,
	input  wire                      rstn_i,
	input  wire                      cyc_i,
	input  wire                      stb_i,
	input  wire video_pkg::wb_addr_t addr_i,
	output video_pkg::wb_data_t      rdata_o,
	output logic                     ack_o,
	input  wire [1:0]                delay_i,
	input  wire                      stall_i
);

import video_pkg::*;

// 256 words, loaded by the testbench
wb_data_t mem [256];

logic [1:0] wait_q;

always_ff @(posedge clk_i or negedge rstn_i) begin
	if (!rstn_i) begin
		ack_o   <= 1'b0;
		wait_q  <= '0;
		rdata_o <= '0;
	end else begin
		ack_o <= 1'b0;
		// no new ack while the last one is still on the bus
		if (cyc_i && stb_i && !ack_o && !stall_i) begin
			if (wait_q >= delay_i) begin
				ack_o   <= 1'b1;
				rdata_o <= mem[addr_i[9:2]];
				wait_q  <= '0;
			end else begin
				wait_q <= wait_q + 1'b1;
			end
		end
	end
end

endmodule

`default_nettype wire

/* sim/tb_video_core.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_video_core;

import video_pkg::*;

localparam int FRAME_WORDS = 32;

logic     clk_i = 1'b0;
logic     pixel_clk_i = 1'b0;
logic     rstn_i;
logic     cfg_cyc, cfg_stb, cfg_we;
wb_addr_t cfg_addr;
wb_sel_t  cfg_sel;
wb_data_t cfg_wdata;
wb_data_t cfg_rdata;
logic     cfg_ack;
logic     fb_cyc, fb_stb, fb_we, fb_ack;
wb_addr_t fb_addr;
wb_sel_t  fb_sel;
wb_data_t fb_rdata;
logic     hsync, vsync, de;
pixel_t   rgb;
logic [1:0] fb_delay, delay_pick;
logic     fb_stall;

// testbench state
logic [15:0] lfsr_q = 16'd40048;
wb_data_t fb_model [256];
wb_addr_t base_model;
int       pix_cnt = 0;
int       black_cnt = 0;
logic     random_on = 1'b0;
logic     allow_black = 1'b0;

always #2 clk_i = ~clk_i;
always #8 pixel_clk_i = ~pixel_clk_i;

video_core #(
	.H_ACTIVE     (8),
	.H_SYNC_START (9),
	.H_SYNC_END   (10),
	.H_TOTAL      (12),
	.V_ACTIVE     (4),
	.V_SYNC_START (5),
	.V_SYNC_END   (6),
	.V_TOTAL      (7),
	.FIFO_ASIZE   (3)
) video_core_i (
	.clk_i       (clk_i),
	.rstn_i      (rstn_i),
	.pixel_clk_i (pixel_clk_i),
	.cfg_cyc_i   (cfg_cyc),
	.cfg_stb_i   (cfg_stb),
	.cfg_we_i    (cfg_we),
	.cfg_addr_i  (cfg_addr),
	.cfg_sel_i   (cfg_sel),
	.cfg_wdata_i (cfg_wdata),
	.cfg_rdata_o (cfg_rdata),
	.cfg_ack_o   (cfg_ack),
	.fb_cyc_o    (fb_cyc),
	.fb_stb_o    (fb_stb),
	.fb_we_o     (fb_we),
	.fb_addr_o   (fb_addr),
	.fb_sel_o    (fb_sel),
	.fb_ack_i    (fb_ack),
	.fb_rdata_i  (fb_rdata),
	.hsync_o     (hsync),
	.vsync_o     (vsync),
	.de_o        (de),
	.rgb_o       (rgb)
);

fb_memory fb_memory_i (
	.clk_i   (clk_i),
	.rstn_i  (rstn_i),
	.cyc_i   (fb_cyc),
	.stb_i   (fb_stb),
	.addr_i  (fb_addr),
	.rdata_o (fb_rdata),
	.ack_o   (fb_ack),
	.delay_i (fb_delay),
	.stall_i (fb_stall)
);

// fibonacci taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

task automatic take_bits(input int n, output logic [31:0] v);
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_q = lfsr_next(lfsr_q);
		v = {v[30:0], lfsr_q[0]};
	end
endtask

task automatic report_failure(input string why);
	$display("%s", why);
	$display("TEST FAILED");
	$fatal(1);
endtask

task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
	if (got !== exp)
		report_failure($sformatf("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp));
endtask

task automatic check_rdata(input string name, input wb_data_t got, input wb_data_t exp);
	if (got !== exp)
		report_failure($sformatf("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp));
endtask

task automatic check_sel(input string name, input wb_sel_t got, input wb_sel_t exp);
	if (got !== exp)
		report_failure($sformatf("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp));
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp)
		report_failure($sformatf("CHECK FAILED t=%0t %s got=%b exp=%b", $time, name, got, exp));
endtask

task automatic check_count(input string name, input int got, input int exp);
	if (got != exp)
		report_failure($sformatf("CHECK FAILED t=%0t %s got=%0d exp=%0d", $time, name, got, exp));
endtask

// one wishbone access, returns read data from the ack cycle
task automatic cfg_access(input logic we, input wb_addr_t addr, input wb_data_t data,
	input wb_sel_t sel, output wb_data_t rdata);
	int n;
	@(posedge clk_i);
	cfg_cyc   <= 1'b1;
	cfg_stb   <= 1'b1;
	cfg_we    <= we;
	cfg_addr  <= addr;
	cfg_sel   <= sel;
	cfg_wdata <= data;
	n = 0;
	do begin
		@(negedge clk_i);
		n++;
		if (n > 20)
			report_failure("config port never acknowledged the access");
	end while (!cfg_ack);
	rdata = cfg_rdata;
	@(posedge clk_i);
	cfg_cyc <= 1'b0;
	cfg_stb <= 1'b0;
	cfg_we  <= 1'b0;
endtask

task automatic cfg_write(input wb_addr_t addr, input wb_data_t data, input wb_sel_t sel);
	wb_data_t unused;
	cfg_access(1'b1, addr, data, sel, unused);
endtask

task automatic cfg_read_check(input string name, input wb_addr_t addr, input wb_data_t exp);
	wb_data_t got;
	cfg_access(1'b0, addr, '0, '1, got);
	check_rdata(name, got, exp);
endtask

// byte-wise merge, base is word aligned
task automatic base_write(input wb_data_t data, input wb_sel_t sel);
	for (int i = 0; i < 4; i++)
		if (sel[i])
			base_model[8*i +: 8] = data[8*i +: 8];
	base_model[1:0] = 2'b00;
	cfg_write(32'(REG_BASE), data, sel);
	cfg_read_check("REG_BASE", 32'(REG_BASE), base_model);
endtask

task automatic wait_vsync_rise();
	int n;
	logic prev;
	n = 0;
	prev = 1'b1;
	forever begin
		@(negedge pixel_clk_i);
		if (vsync && !prev)
			break;
		prev = vsync;
		n++;
		if (n > 300)
			report_failure("vsync_o never rose");
	end
endtask

// one frame of 84 pixel clocks from the vsync edge
task automatic measure_frame();
	int hs_high, hs_len, vs_high, de_high, de_runs, de_len;
	logic hs_prev, de_prev;
	hs_high = 0;
	hs_len  = 0;
	vs_high = 0;
	de_high = 0;
	de_runs = 0;
	de_len  = 0;
	hs_prev = 1'b0;
	de_prev = 1'b0;
	wait_vsync_rise();
	for (int i = 0; i < 84; i++) begin
		if (i > 0)
			@(negedge pixel_clk_i);
		hs_high += hsync;
		vs_high += vsync;
		de_high += de;
		if (hsync)
			hs_len++;
		else if (hs_prev) begin
			check_count("hsync_o run", hs_len, 2);
			hs_len = 0;
		end
		if (de) begin
			de_len++;
			if (!de_prev)
				de_runs++;
		end else if (de_prev) begin
			check_count("de_o run", de_len, 8);
			de_len = 0;
		end
		hs_prev = hsync;
		de_prev = de;
	end
	check_count("hsync_o clocks", hs_high, 14);
	check_count("vsync_o clocks", vs_high, 24);
	check_count("de_o clocks", de_high, 32);
	check_count("de_o lines", de_runs, 4);
endtask

// pixel model, black on underflow keeps the stream where it was
always @(negedge pixel_clk_i) begin
	pixel_t exp;
	if (rstn_i && de) begin
		random_on = 1'b1;
		if (allow_black && rgb == '0) begin
			black_cnt++;
		end else begin
			exp = fb_model[base_model[9:2] + (pix_cnt % FRAME_WORDS)][23:0];
			check_pixel("rgb_o", rgb, exp);
			pix_cnt++;
		end
	end
end

// new ack delay after every acknowledged read
always @(negedge clk_i) begin
	logic [31:0] r;
	if (random_on && fb_ack) begin
		take_bits(2, r);
		delay_pick = 2'(r % 3);
	end
end

always @(posedge clk_i)
	fb_delay <= delay_pick;

// fetch port does plain reads on all byte lanes
always @(negedge clk_i) begin
	if (rstn_i && fb_cyc) begin
		check_bit("fb_stb_o", fb_stb, 1'b1);
		check_bit("fb_we_o", fb_we, 1'b0);
		check_sel("fb_sel_o", fb_sel, 4'hF);
	end
end

initial begin
	wb_data_t w;
	int n;
	rstn_i     = 1'b0;
	cfg_cyc    = 1'b0;
	cfg_stb    = 1'b0;
	cfg_we     = 1'b0;
	cfg_addr   = '0;
	cfg_sel    = '0;
	cfg_wdata  = '0;
	fb_delay   = '0;
	delay_pick = '0;
	fb_stall   = 1'b0;
	base_model = '0;
	// random framebuffer, no pixel is pure black
	for (int i = 0; i < 256; i++) begin
		take_bits(32, w);
		if (w[23:0] == '0)
			w[0] = 1'b1;
		fb_model[i] = w;
		fb_memory_i.mem[i] = w;
	end
	repeat (5) @(posedge clk_i);
	@(negedge clk_i);
	check_bit("fb_cyc_o", fb_cyc, 1'b0);
	check_bit("cfg_ack_o", cfg_ack, 1'b0);
	check_bit("hsync_o", hsync, 1'b0);
	check_bit("vsync_o", vsync, 1'b0);
	check_bit("de_o", de, 1'b0);
	check_pixel("rgb_o", rgb, '0);
	@(posedge clk_i);
	rstn_i <= 1'b1;

	// register readback with partial selects
	cfg_write(32'(REG_CTRL), 32'h0, 4'hF);
	cfg_read_check("REG_CTRL", 32'(REG_CTRL), 32'h0);
	base_write(32'h12345677, 4'hF);
	base_write(32'hAABBCCDD, 4'b0101);
	base_write(32'h00000100, 4'hF);

	// two whole frames of pixels
	cfg_write(32'(REG_CTRL), 32'h1, 4'hF);
	cfg_read_check("REG_CTRL", 32'(REG_CTRL), 32'h1);
	n = 0;
	while (pix_cnt < 2 * FRAME_WORDS) begin
		@(negedge pixel_clk_i);
		n++;
		if (n > 400)
			report_failure("two frames of pixels did not arrive in time");
	end
	cfg_read_check("REG_STATUS", 32'(REG_STATUS), 32'h0);
	measure_frame();

	// starve the fifo
	allow_black = 1'b1;
	@(posedge clk_i);
	fb_stall <= 1'b1;
	n = 0;
	while (black_cnt < 4) begin
		@(negedge pixel_clk_i);
		n++;
		if (n > 300)
			report_failure("no black pixels while the framebuffer was stalled");
	end
	repeat (10) @(posedge clk_i);
	cfg_read_check("REG_STATUS", 32'(REG_STATUS), 32'h1);
	@(posedge clk_i);
	fb_stall <= 1'b0;
	wait_vsync_rise();
	wait_vsync_rise();
	cfg_write(32'(REG_STATUS), 32'h1, 4'hF);
	cfg_read_check("REG_STATUS", 32'(REG_STATUS), 32'h0);
	allow_black = 1'b0;

	// disable stops the bus and the picture
	cfg_write(32'(REG_CTRL), 32'h0, 4'hF);
	n = 0;
	do begin
		@(negedge clk_i);
		n++;
		if (n > 20)
			report_failure("fb_cyc_o stayed high after disable");
	end while (fb_cyc);
	repeat (4) @(negedge pixel_clk_i);
	for (int i = 0; i < 100; i++) begin
		@(negedge pixel_clk_i);
		check_bit("de_o", de, 1'b0);
	end

	$display("TEST OK");
	$finish;
end

endmodule

`default_nettype wire

/* verilog/pixel_afifo.sv */
`timescale 1ns/10ps
`default_nettype none

module pixel_afifo #(
	parameter int ASIZE = 6
) (
	input  wire                    wclk_i,
	input  wire                    wrstn_i,
	input  wire                    push_i,
	input  wire video_pkg::pixel_t wdata_i,
	output logic                   full_o,
	input  wire                    rclk_i,
	input  wire                    rrstn_i,
	input  wire                    pop_i,
	output video_pkg::pixel_t      rdata_o,
	output logic                   empty_o
);

import video_pkg::*;

localparam int DEPTH = 2 ** ASIZE;

pixel_t mem [DEPTH];

// pointers carry one extra wrap bit
logic [ASIZE:0] wbin_q, wgray_q, wbin_n, wgray_n;
logic [ASIZE:0] rbin_q, rgray_q, rbin_n, rgray_n;
logic [ASIZE:0] wq1_rgray_q, wq2_rgray_q;
logic [ASIZE:0] rq1_wgray_q, rq2_wgray_q;
logic           full_q, empty_q;
logic           do_push, do_pop;
pixel_t         rdata_q;

// write side in clk_i
assign do_push = push_i & ~full_q;
assign wbin_n  = wbin_q + {{ASIZE{1'b0}}, do_push};
assign wgray_n = (wbin_n >> 1) ^ wbin_n;

always_ff @(posedge wclk_i) begin
	if (do_push)
		mem[wbin_q[ASIZE-1:0]] <= wdata_i;
end

always_ff @(posedge wclk_i or negedge wrstn_i) begin
	if (!wrstn_i) begin
		wbin_q      <= '0;
		wgray_q     <= '0;
		wq1_rgray_q <= '0;
		wq2_rgray_q <= '0;
		full_q      <= 1'b0;
	end else begin
		wbin_q      <= wbin_n;
		wgray_q     <= wgray_n;
		wq1_rgray_q <= rgray_q;
		wq2_rgray_q <= wq1_rgray_q;
		// full when gray pointers differ in the two top bits only
		full_q <= (wgray_n == {~wq2_rgray_q[ASIZE:ASIZE-1], wq2_rgray_q[ASIZE-2:0]});
	end
end

// read side in pixel_clk_i
assign do_pop  = pop_i & ~empty_q;
assign rbin_n  = rbin_q + {{ASIZE{1'b0}}, do_pop};
assign rgray_n = (rbin_n >> 1) ^ rbin_n;

// registered read, data one clock after pop
always_ff @(posedge rclk_i) begin
	if (do_pop)
		rdata_q <= mem[rbin_q[ASIZE-1:0]];
end

always_ff @(posedge rclk_i or negedge rrstn_i) begin
	if (!rrstn_i) begin
		rbin_q      <= '0;
		rgray_q     <= '0;
		rq1_wgray_q <= '0;
		rq2_wgray_q <= '0;
		empty_q     <= 1'b1;
	end else begin
		rbin_q      <= rbin_n;
		rgray_q     <= rgray_n;
		rq1_wgray_q <= wgray_q;
		rq2_wgray_q <= rq1_wgray_q;
		empty_q     <= (rgray_n == rq2_wgray_q);
	end
end

assign full_o  = full_q;
assign empty_o = empty_q;
assign rdata_o = rdata_q;

// the fetch side must respect full
a_no_push_full: assert property (@(posedge wclk_i) disable iff (!wrstn_i)
	push_i |-> !full_o);

// the timing side must respect empty
a_no_pop_empty: assert property (@(posedge rclk_i) disable iff (!rrstn_i)
	pop_i |-> !empty_o);

endmodule

`default_nettype wire

/* verilog/video_core.sv */
`timescale 1ns/10ps
`default_nettype none

module video_core #(
	parameter int H_ACTIVE     = 640,
	parameter int H_SYNC_START = 656,
	parameter int H_SYNC_END   = 751,
	parameter int H_TOTAL      = 800,
	parameter int V_ACTIVE     = 480,
	parameter int V_SYNC_START = 490,
	parameter int V_SYNC_END   = 491,
	parameter int V_TOTAL      = 525,
	parameter int FIFO_ASIZE   = 6
) (
	input  wire                      clk_i,
	input  wire                      rstn_i,
	input  wire                      pixel_clk_i,
	input  wire                      cfg_cyc_i,
	input  wire                      cfg_stb_i,
	input  wire                      cfg_we_i,
	input  wire video_pkg::wb_addr_t cfg_addr_i,
	input  wire video_pkg::wb_sel_t  cfg_sel_i,
	input  wire video_pkg::wb_data_t cfg_wdata_i,
	output video_pkg::wb_data_t      cfg_rdata_o,
	output logic                     cfg_ack_o,
	output logic                     fb_cyc_o,
	output logic                     fb_stb_o,
	output logic                     fb_we_o,
	output video_pkg::wb_addr_t      fb_addr_o,
	output video_pkg::wb_sel_t       fb_sel_o,
	input  wire                      fb_ack_i,
	input  wire video_pkg::wb_data_t fb_rdata_i,
	output logic                     hsync_o,
	output logic                     vsync_o,
	output logic                     de_o,
	output video_pkg::pixel_t        rgb_o
);

import video_pkg::*;

// clk_i side
logic     enable;
wb_addr_t base;
logic     push;
pixel_t   push_data;
logic     full;

// pixel_clk_i side
logic     enable_pix;
logic     pop;
pixel_t   pop_data;
logic     empty;
logic     underflow;

video_core_ctrl video_core_ctrl_i (
	.clk_i        (clk_i),
	.rstn_i       (rstn_i),
	.pixel_clk_i  (pixel_clk_i),
	.cfg_cyc_i    (cfg_cyc_i),
	.cfg_stb_i    (cfg_stb_i),
	.cfg_we_i     (cfg_we_i),
	.cfg_addr_i   (cfg_addr_i),
	.cfg_sel_i    (cfg_sel_i),
	.cfg_wdata_i  (cfg_wdata_i),
	.cfg_rdata_o  (cfg_rdata_o),
	.cfg_ack_o    (cfg_ack_o),
	.underflow_i  (underflow),
	.enable_o     (enable),
	.enable_pix_o (enable_pix),
	.base_o       (base)
);

video_fetch #(
	.H_ACTIVE (H_ACTIVE),
	.V_ACTIVE (V_ACTIVE)
) video_fetch_i (
	.clk_i       (clk_i),
	.rstn_i      (rstn_i),
	.enable_i    (enable),
	.base_i      (base),
	.fb_cyc_o    (fb_cyc_o),
	.fb_stb_o    (fb_stb_o),
	.fb_we_o     (fb_we_o),
	.fb_addr_o   (fb_addr_o),
	.fb_sel_o    (fb_sel_o),
	.fb_ack_i    (fb_ack_i),
	.fb_rdata_i  (fb_rdata_i),
	.push_o      (push),
	.push_data_o (push_data),
	.full_i      (full)
);

// crossing from clk_i into pixel_clk_i
pixel_afifo #(
	.ASIZE (FIFO_ASIZE)
) pixel_afifo_i (
	.wclk_i  (clk_i),
	.wrstn_i (rstn_i),
	.push_i  (push),
	.wdata_i (push_data),
	.full_o  (full),
	.rclk_i  (pixel_clk_i),
	.rrstn_i (rstn_i),
	.pop_i   (pop),
	.rdata_o (pop_data),
	.empty_o (empty)
);

video_timing #(
	.H_ACTIVE     (H_ACTIVE),
	.H_SYNC_START (H_SYNC_START),
	.H_SYNC_END   (H_SYNC_END),
	.H_TOTAL      (H_TOTAL),
	.V_ACTIVE     (V_ACTIVE),
	.V_SYNC_START (V_SYNC_START),
	.V_SYNC_END   (V_SYNC_END),
	.V_TOTAL      (V_TOTAL)
) video_timing_i (
	.pixel_clk_i (pixel_clk_i),
	.rstn_i      (rstn_i),
	.enable_i    (enable_pix),
	.empty_i     (empty),
	.pop_o       (pop),
	.pixel_i     (pop_data),
	.hsync_o     (hsync_o),
	.vsync_o     (vsync_o),
	.de_o        (de_o),
	.rgb_o       (rgb_o),
	.underflow_o (underflow)
);

endmodule

`default_nettype wire

/* verilog/video_core_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module video_core_ctrl (
	input  wire                      clk_i,
	input  wire                      rstn_i,
	input  wire                      pixel_clk_i,
	input  wire                      cfg_cyc_i,
	input  wire                      cfg_stb_i,
	input  wire                      cfg_we_i,
	input  wire video_pkg::wb_addr_t cfg_addr_i,
	input  wire video_pkg::wb_sel_t  cfg_sel_i,
	input  wire video_pkg::wb_data_t cfg_wdata_i,
	output video_pkg::wb_data_t      cfg_rdata_o,
	output logic                     cfg_ack_o,
	input  wire                      underflow_i,
	output logic                     enable_o,
	output logic                     enable_pix_o,
	output video_pkg::wb_addr_t      base_o
);

import video_pkg::*;

logic     req;
logic     access;
logic     ack_q;
wb_data_t rd_mux;
wb_data_t rdata_q;
logic     enable_q;
wb_addr_t base_q;
logic     underflow_q;
logic     status_clr;
logic [1:0] en_sync_q;
logic     uf_tgl_q;
logic [2:0] uf_sync_q;
logic     uf_pulse;

assign req = cfg_cyc_i & cfg_stb_i;
// first cycle of a request, ack follows on the next edge
assign access = req & ~ack_q;

// write 1 to clear the sticky flag
assign status_clr = access & cfg_we_i & (cfg_addr_i[3:0] == REG_STATUS) &
	cfg_sel_i[0] & cfg_wdata_i[STATUS_UNDERFLOW_BIT];

always_ff @(posedge clk_i or negedge rstn_i) begin
	if (!rstn_i) begin
		ack_q       <= 1'b0;
		enable_q    <= 1'b0;
		base_q      <= '0;
		underflow_q <= 1'b0;
	end else begin
		ack_q <= access;
		if (access && cfg_we_i) begin
			case (cfg_addr_i[3:0])
				REG_CTRL: begin
					if (cfg_sel_i[0])
						enable_q <= cfg_wdata_i[CTRL_ENABLE_BIT];
				end
				REG_BASE: begin
					for (int i = 0; i < WB_SEL_W; i++)
						if (cfg_sel_i[i])
							base_q[8*i +: 8] <= cfg_wdata_i[8*i +: 8];
					// word aligned framebuffer
					base_q[1:0] <= 2'b00;
				end
				default: ;
			endcase
		end
		// a new underflow wins over a clear in the same cycle
		if (uf_pulse)
			underflow_q <= 1'b1;
		else if (status_clr)
			underflow_q <= 1'b0;
	end
end

always_comb begin
	rd_mux = '0;
	case (cfg_addr_i[3:0])
		REG_CTRL:   rd_mux[CTRL_ENABLE_BIT] = enable_q;
		REG_BASE:   rd_mux = base_q;
		REG_STATUS: rd_mux[STATUS_UNDERFLOW_BIT] = underflow_q;
		default: ;
	endcase
end

// read data lands together with ack
always_ff @(posedge clk_i) begin
	if (access && !cfg_we_i)
		rdata_q <= rd_mux;
end

// enable into the pixel domain
always_ff @(posedge pixel_clk_i or negedge rstn_i) begin
	if (!rstn_i) begin
		en_sync_q <= '0;
		uf_tgl_q  <= 1'b0;
	end else begin
		en_sync_q <= {en_sync_q[0], enable_q};
		// pulse becomes a level change
		if (underflow_i)
			uf_tgl_q <= ~uf_tgl_q;
	end
end

// toggle back into clk_i, edge gives one pulse
always_ff @(posedge clk_i or negedge rstn_i) begin
	if (!rstn_i)
		uf_sync_q <= '0;
	else
		uf_sync_q <= {uf_sync_q[1:0], uf_tgl_q};
end

assign uf_pulse = uf_sync_q[2] ^ uf_sync_q[1];

assign cfg_ack_o    = ack_q;
assign cfg_rdata_o  = rdata_q;
assign enable_o     = enable_q;
assign enable_pix_o = en_sync_q[1];
assign base_o       = base_q;

// ack only while the master still holds its request
a_ack_with_stb: assert property (@(posedge clk_i) disable iff (!rstn_i)
	cfg_ack_o |-> cfg_cyc_i && cfg_stb_i);

endmodule

`default_nettype wire

/* verilog/video_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

module video_fetch #(
	parameter int H_ACTIVE = 640,
	parameter int V_ACTIVE = 480
) (
	input  wire                      clk_i,
	input  wire                      rstn_i,
	input  wire                      enable_i,
	input  wire video_pkg::wb_addr_t base_i,
	output logic                     fb_cyc_o,
	output logic                     fb_stb_o,
	output logic                     fb_we_o,
	output video_pkg::wb_addr_t      fb_addr_o,
	output video_pkg::wb_sel_t       fb_sel_o,
	input  wire                      fb_ack_i,
	input  wire video_pkg::wb_data_t fb_rdata_i,
	output logic                     push_o,
	output video_pkg::pixel_t        push_data_o,
	input  wire                      full_i
);

import video_pkg::*;

// one word per pixel
localparam int unsigned FRAME_PIXELS = H_ACTIVE * V_ACTIVE;
localparam int unsigned CNT_W        = $clog2(FRAME_PIXELS);

typedef enum logic {
	IDLE,
	FETCHING
} state_t;

state_t     state_q;
wb_addr_t   addr_q;
logic [CNT_W-1:0] cnt_q;
logic       done;
logic       last;

// a read completes on the ack edge
assign done = (state_q == FETCHING) && fb_ack_i;
assign last = (cnt_q == CNT_W'(FRAME_PIXELS - 1));

always_ff @(posedge clk_i or negedge rstn_i) begin
	if (!rstn_i) begin
		state_q <= IDLE;
		addr_q  <= '0;
		cnt_q   <= '0;
	end else begin
		case (state_q)
			IDLE: begin
				if (!enable_i) begin
					// next enable starts at the top of the frame
					addr_q <= base_i;
					cnt_q  <= '0;
				end else if (!full_i) begin
					state_q <= FETCHING;
				end
			end
			FETCHING: begin
				// finish the cycle even if enable drops meanwhile
				if (fb_ack_i) begin
					state_q <= IDLE;
					if (last) begin
						addr_q <= base_i;
						cnt_q  <= '0;
					end else begin
						addr_q <= addr_q + 32'd4;
						cnt_q  <= cnt_q + 1'b1;
					end
				end
			end
			default: state_q <= IDLE;
		endcase
	end
end

// single beat reads only
assign fb_cyc_o  = (state_q == FETCHING);
assign fb_stb_o  = (state_q == FETCHING);
assign fb_we_o   = 1'b0;
assign fb_sel_o  = '1;
assign fb_addr_o = addr_q;

// low bits of the word carry the pixel
assign push_o      = done;
assign push_data_o = fb_rdata_i[PIXEL_W-1:0];

// bus rule, address frozen until the slave answers
a_addr_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
	fb_stb_o && !fb_ack_i |=> fb_stb_o && $stable(fb_addr_o));

endmodule

`default_nettype wire

/* verilog/video_timing.sv */
`timescale 1ns/10ps
`default_nettype none

module video_timing #(
	parameter int H_ACTIVE     = 640,
	parameter int H_SYNC_START = 656,
	parameter int H_SYNC_END   = 751,
	parameter int H_TOTAL      = 800,
	parameter int V_ACTIVE     = 480,
	parameter int V_SYNC_START = 490,
	parameter int V_SYNC_END   = 491,
	parameter int V_TOTAL      = 525
) (
	input  wire                    pixel_clk_i,
	input  wire                    rstn_i,
	input  wire                    enable_i,
	input  wire                    empty_i,
	output logic                   pop_o,
	input  wire video_pkg::pixel_t pixel_i,
	output logic                   hsync_o,
	output logic                   vsync_o,
	output logic                   de_o,
	output video_pkg::pixel_t      rgb_o,
	output logic                   underflow_o
);

import video_pkg::*;

coord_t x_q, y_q;
coord_t x_n, y_n;
logic   running_q, run_n;
logic   draw, draw_n;
logic   hsync, vsync;
logic   starve_q;

// position on the next clock
always_comb begin
	run_n = running_q;
	x_n   = x_q;
	y_n   = y_q;
	if (!enable_i) begin
		run_n = 1'b0;
		x_n   = '0;
		y_n   = '0;
	end else if (!running_q) begin
		// wait for the first fetched pixel
		run_n = ~empty_i;
	end else if (x_q == coord_t'(H_TOTAL - 1)) begin
		x_n = '0;
		y_n = (y_q == coord_t'(V_TOTAL - 1)) ? '0 : y_q + 1'b1;
	end else begin
		x_n = x_q + 1'b1;
	end
end

always_ff @(posedge pixel_clk_i or negedge rstn_i) begin
	if (!rstn_i) begin
		running_q <= 1'b0;
		x_q       <= '0;
		y_q       <= '0;
	end else begin
		running_q <= run_n;
		x_q       <= x_n;
		y_q       <= y_n;
	end
end

// window decode, sync ends are inclusive
assign draw  = running_q && (x_q < coord_t'(H_ACTIVE)) && (y_q < coord_t'(V_ACTIVE));
assign hsync = running_q && (x_q >= coord_t'(H_SYNC_START)) && (x_q <= coord_t'(H_SYNC_END));
assign vsync = running_q && (y_q >= coord_t'(V_SYNC_START)) && (y_q <= coord_t'(V_SYNC_END));

// pop one position ahead so fifo data meets the counters
assign draw_n = run_n && (x_n < coord_t'(H_ACTIVE)) && (y_n < coord_t'(V_ACTIVE));
// no pop on empty keeps the stream in order
assign pop_o  = draw_n & ~empty_i;

always_ff @(posedge pixel_clk_i or negedge rstn_i) begin
	if (!rstn_i) begin
		starve_q <= 1'b0;
		hsync_o  <= 1'b0;
		vsync_o  <= 1'b0;
		de_o     <= 1'b0;
		rgb_o    <= '0;
	end else begin
		starve_q <= draw_n & empty_i;
		hsync_o  <= hsync;
		vsync_o  <= vsync;
		de_o     <= draw;
		// black outside the draw area and on a missed pixel
		rgb_o    <= (draw && !starve_q) ? pixel_i : '0;
	end
end

// one pulse per missed pixel
assign underflow_o = starve_q;

endmodule

`default_nettype wire

/* video_core.f */
common/video_pkg.sv
verilog/video_core_ctrl.sv
verilog/video_fetch.sv
verilog/pixel_afifo.sv
verilog/video_timing.sv
verilog/video_core.sv
sim/fb_memory.sv
sim/tb_video_core.sv
